/* armPkg.sv */
// ---------------------------------------------------------------------------
// Shared types and constants of the ARMv4 subset core: instruction word
// views, major opcodes, DP commands, ALU ops, immediate and shift selects
// ---------------------------------------------------------------------------
package armPkg;

   // Second operand of a data-processing instruction
   typedef struct packed {
      logic [3:0] rot;              // Not applied, imm8 is zero-extended
      logic [7:0] imm8;
   } src2ImmT;

   typedef struct packed {
      logic [4:0] shamt;
      logic [1:0] sh;
      logic       shReg;            // 0 for shift by constant
      logic [3:0] rm;
   } src2RegT;

   typedef union packed {
      src2ImmT immView;
      src2RegT regView;
   } src2T;

   typedef struct packed {
      logic [3:0] cond;
      logic [1:0] op;
      logic       immOp;            // 1 selects imm8 operand
      logic [3:0] cmd;
      logic       s;                // Update flags
      logic [3:0] rn;
      logic [3:0] rd;
      src2T       src2;
   } dpFieldsT;

   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic [5:0]  funct;           // Bit 0 is L, set for LDR
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] imm12;
   } memFieldsT;

   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic [1:0]  funct;
      logic [23:0] imm24;
   } brFieldsT;

   // One fetched word, decoded three ways
   typedef union packed {
      dpFieldsT  dpView;
      memFieldsT memView;
      brFieldsT  brView;
   } instrT;

   localparam logic [1:0] OP_DP  = 2'b00;
   localparam logic [1:0] OP_MEM = 2'b01;
   localparam logic [1:0] OP_BR  = 2'b10;

   localparam logic [3:0] CMD_AND = 4'b0000;
   localparam logic [3:0] CMD_EOR = 4'b0001;
   localparam logic [3:0] CMD_SUB = 4'b0010;
   localparam logic [3:0] CMD_ADD = 4'b0100;
   localparam logic [3:0] CMD_CMP = 4'b1010;
   localparam logic [3:0] CMD_ORR = 4'b1100;

   localparam int ALU_OP_W = 3;
   localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'b000;
   localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'b001;
   localparam logic [ALU_OP_W-1:0] ALU_AND = 3'b010;
   localparam logic [ALU_OP_W-1:0] ALU_ORR = 3'b011;
   localparam logic [ALU_OP_W-1:0] ALU_EOR = 3'b100;

   localparam logic [1:0] IMM_DP8   = 2'b00;
   localparam logic [1:0] IMM_MEM12 = 2'b01;
   localparam logic [1:0] IMM_BR24  = 2'b10;

   localparam logic [1:0] SH_LSL = 2'b00;
   localparam logic [1:0] SH_LSR = 2'b01;
   localparam logic [1:0] SH_ASR = 2'b10;
   localparam logic [1:0] SH_ROR = 2'b11;

   // Bit positions in the NZCV word
   localparam int FLAG_N = 3;
   localparam int FLAG_Z = 2;
   localparam int FLAG_C = 1;
   localparam int FLAG_V = 0;

   localparam logic [3:0] COND_AL = 4'b1110;
   localparam logic [3:0] PC_REG  = 4'd15;

endpackage

/* alu.sv */
// ---------------------------------------------------------------------------
// 32-bit ALU: add, subtract, AND, ORR, EOR with NZCV flags
// ---------------------------------------------------------------------------
module alu import armPkg::*; (
   input  logic [31:0]         a,
   input  logic [31:0]         b,
   input  logic [ALU_OP_W-1:0] aluOp,
   output logic [31:0]         result,
   output logic [3:0]          flags
);

   logic        sub;
   logic        arith;
   logic [31:0] bInv;
   logic [32:0] sum;

   assign sub   = (aluOp == ALU_SUB);
   assign arith = (aluOp == ALU_ADD) || sub;

   // Subtract as a + ~b + 1 through the same adder
   assign bInv = sub ? ~b : b;
   assign sum  = {1'b0, a} + {1'b0, bInv} + {32'b0, sub};

   always_comb begin
      case (aluOp)
         ALU_ADD: result = sum[31:0];
         ALU_SUB: result = sum[31:0];
         ALU_AND: result = a & b;
         ALU_ORR: result = a | b;
         ALU_EOR: result = a ^ b;
         default: result = '0;
      endcase
   end

   assign flags[FLAG_N] = result[31];
   assign flags[FLAG_Z] = (result == 32'b0);
   assign flags[FLAG_C] = arith & sum[32];   // Carry out, no borrow on SUB
   // Operands agree in sign after inversion but the sum does not
   assign flags[FLAG_V] = arith & ~(a[31] ^ b[31] ^ sub) & (a[31] ^ sum[31]);

endmodule

/* regFile.sv */
// ---------------------------------------------------------------------------
// Register file, R0 to R14 in storage, R15 supplied as PC plus 8
// ---------------------------------------------------------------------------
module regFile import armPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        we,
   input  logic [3:0]  ra1,
   input  logic [3:0]  ra2,
   input  logic [3:0]  wa,
   input  logic [31:0] wd,
   input  logic [31:0] r15,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [15];

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 15; i++) regs[i] <= '0;
      end else if (we && wa != PC_REG) begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = (ra1 == PC_REG) ? r15 : regs[ra1];
   assign rd2 = (ra2 == PC_REG) ? r15 : regs[ra2];

   // Decoder and generator together keep PC writes out of the subset
   assert property (@(posedge clk) disable iff (reset) we |-> wa != PC_REG)
      else $error("register write to R15");

endmodule

/* controlDecoder.sv */
// ---------------------------------------------------------------------------
// Main decoder and ALU decoder, raw control levels before condition check
// ---------------------------------------------------------------------------
module controlDecoder import armPkg::*; (
   input  instrT               instr,
   output logic                regW,
   output logic                memW,
   output logic                branch,
   output logic                memToReg,
   output logic                aluSrc,
   output logic                noWrite,
   output logic [1:0]          immSrc,
   output logic [1:0]          regSrc,
   output logic [ALU_OP_W-1:0] aluOp,
   output logic [1:0]          flagW
);

   logic [3:0] cmd;
   logic       isArith;

   assign cmd = instr.dpView.cmd;

   // Main decoder
   always_comb begin
      regW     = 1'b0;
      memW     = 1'b0;
      branch   = 1'b0;
      memToReg = 1'b0;
      aluSrc   = 1'b0;
      immSrc   = IMM_DP8;
      regSrc   = 2'b00;   // Bit 0 reads R15 as rn, bit 1 reads rd as rm
      case (instr.memView.op)
         OP_DP: begin
            regW   = 1'b1;
            aluSrc = instr.dpView.immOp;
         end
         OP_MEM: begin
            aluSrc = 1'b1;
            immSrc = IMM_MEM12;
            if (instr.memView.funct[0]) begin   // LDR
               regW     = 1'b1;
               memToReg = 1'b1;
            end else begin                       // STR
               memW   = 1'b1;
               regSrc = 2'b10;
            end
         end
         OP_BR: begin
            branch = 1'b1;
            aluSrc = 1'b1;
            immSrc = IMM_BR24;
            regSrc = 2'b01;   // Target is PC+8 plus offset
         end
         default: ;
      endcase
   end

   // ALU decoder, only data processing picks its own operation
   assign isArith = (cmd == CMD_ADD) || (cmd == CMD_SUB) || (cmd == CMD_CMP);

   always_comb begin
      aluOp   = ALU_ADD;   // Address and branch target sums
      noWrite = 1'b0;
      flagW   = 2'b00;
      if (instr.memView.op == OP_DP) begin
         case (cmd)
            CMD_SUB: aluOp = ALU_SUB;
            CMD_AND: aluOp = ALU_AND;
            CMD_ORR: aluOp = ALU_ORR;
            CMD_EOR: aluOp = ALU_EOR;
            CMD_CMP: begin
               aluOp   = ALU_SUB;
               noWrite = 1'b1;
            end
            default: aluOp = ALU_ADD;
         endcase
         flagW[1] = instr.dpView.s;             // N and Z
         flagW[0] = instr.dpView.s & isArith;   // C and V only for arithmetic
      end
   end

   // Opcode 11 is outside the subset and must never be fetched
   always_comb begin
      assert final (instr.memView.op !== 2'b11)
         else $error("reserved major opcode 11 fetched");
   end

endmodule

/* condUnit.sv */
// ---------------------------------------------------------------------------
// NZCV flag registers, condition evaluation, gating of write and branch
// ---------------------------------------------------------------------------
module condUnit import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  instrT      instr,
   input  logic [3:0] aluFlags,
   input  logic [1:0] flagW,
   input  logic       regW,
   input  logic       memW,
   input  logic       branch,
   input  logic       noWrite,
   output logic       regWrite,
   output logic       memWrite,
   output logic       pcSrc
);

   logic [3:0] flags;
   logic [1:0] flagWrite;
   logic       condEx;
   logic       n, z, c, v, ge;

   assign n  = flags[FLAG_N];
   assign z  = flags[FLAG_Z];
   assign c  = flags[FLAG_C];
   assign v  = flags[FLAG_V];
   assign ge = (n == v);

   always_comb begin
      case (instr.dpView.cond)
         4'b0000: condEx = z;            // EQ
         4'b0001: condEx = ~z;           // NE
         4'b0010: condEx = c;            // CS
         4'b0011: condEx = ~c;           // CC
         4'b0100: condEx = n;            // MI
         4'b0101: condEx = ~n;           // PL
         4'b0110: condEx = v;            // VS
         4'b0111: condEx = ~v;           // VC
         4'b1000: condEx = c & ~z;       // HI
         4'b1001: condEx = ~c | z;       // LS
         4'b1010: condEx = ge;           // GE
         4'b1011: condEx = ~ge;          // LT
         4'b1100: condEx = ~z & ge;      // GT
         4'b1101: condEx = z | ~ge;      // LE
         COND_AL: condEx = 1'b1;
         default: condEx = 1'b0;
      endcase
   end

   assign flagWrite = flagW & {2{condEx}};
   assign regWrite  = regW & condEx & ~noWrite;
   assign memWrite  = memW & condEx;
   assign pcSrc     = branch & condEx;

   // N/Z and C/V pairs load separately, visible to the next instruction
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         if (flagWrite[1]) begin
            flags[FLAG_N] <= aluFlags[FLAG_N];
            flags[FLAG_Z] <= aluFlags[FLAG_Z];
         end
         if (flagWrite[0]) begin
            flags[FLAG_C] <= aluFlags[FLAG_C];
            flags[FLAG_V] <= aluFlags[FLAG_V];
         end
      end
   end

   // Code 1111 is unconditional space, never issued to this core
   assert property (@(posedge clk) disable iff (reset) instr.dpView.cond != 4'b1111)
      else $error("condition code 1111 fetched");

endmodule

/* datapath.sv */
// ---------------------------------------------------------------------------
// PC and next-PC logic, register addressing, immediate extension,
// operand shifter and result selection
// ---------------------------------------------------------------------------
module datapath import armPkg::*; #(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  logic                clk,
   input  logic                reset,
   input  instrT               instr,
   input  logic [31:0]         readData,
   input  logic [1:0]          regSrc,
   input  logic [1:0]          immSrc,
   input  logic [ALU_OP_W-1:0] aluOp,
   input  logic                regWrite,
   input  logic                aluSrc,
   input  logic                memToReg,
   input  logic                pcSrc,
   output logic [3:0]          aluFlags,
   output logic [31:0]         pc,
   output logic [31:0]         dataAdr,
   output logic [31:0]         writeData
);

   logic [31:0] pcPlus4, pcPlus8, pcNext;
   logic [3:0]  ra1, ra2;
   logic [31:0] srcA, rd2, srcB, shifted, extImm, aluResult, result;
   logic [63:0] rotWide;
   logic [4:0]  shamt;

   assign pcPlus4 = pc + 32'd4;
   assign pcPlus8 = pcPlus4 + 32'd4;
   assign pcNext  = pcSrc ? result : pcPlus4;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) pc <= RESET_PC;
      else       pc <= pcNext;
   end

   assign ra1 = regSrc[0] ? PC_REG : instr.dpView.rn;
   assign ra2 = regSrc[1] ? instr.memView.rd : instr.dpView.src2.regView.rm;

   regFile uRegs (
      .clk(clk), .reset(reset), .we(regWrite), .ra1(ra1), .ra2(ra2),
      .wa(instr.dpView.rd), .wd(result), .r15(pcPlus8), .rd1(srcA), .rd2(rd2)
   );

   always_comb begin
      case (immSrc)
         IMM_DP8:   extImm = {24'b0, instr.dpView.src2.immView.imm8};
         IMM_MEM12: extImm = {20'b0, instr.memView.imm12};
         IMM_BR24:  extImm = {{6{instr.brView.imm24[23]}}, instr.brView.imm24, 2'b00};
         default:   extImm = '0;
      endcase
   end

   // Constant shift, amount zero passes rm through for all types
   assign shamt   = instr.dpView.src2.regView.shamt;
   assign rotWide = {rd2, rd2} >> shamt;

   always_comb begin
      case (instr.dpView.src2.regView.sh)
         SH_LSL: shifted = rd2 << shamt;
         SH_LSR: shifted = rd2 >> shamt;
         SH_ASR: shifted = $signed(rd2) >>> shamt;
         SH_ROR: shifted = rotWide[31:0];
      endcase
   end

   assign srcB = aluSrc ? extImm : shifted;

   alu uAlu (.a(srcA), .b(srcB), .aluOp(aluOp), .result(aluResult), .flags(aluFlags));

   assign result    = memToReg ? readData : aluResult;
   assign dataAdr   = aluResult;
   assign writeData = rd2;   // Unshifted rd for STR

endmodule

/* armCore.sv */
// ---------------------------------------------------------------------------
// Single-cycle ARMv4 subset core, top level
// ---------------------------------------------------------------------------
module armCore import armPkg::*; #(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        reset,
   input  instrT       instr,
   input  logic [31:0] readData,
   output logic [31:0] pc,
   output logic        memWrite,
   output logic [31:0] dataAdr,
   output logic [31:0] writeData
);

   logic                regW, memW, branch, memToReg, aluSrc, noWrite;
   logic [1:0]          immSrc, regSrc, flagW;
   logic [ALU_OP_W-1:0] aluOp;
   logic                regWrite, pcSrc;   // After condition check
   logic [3:0]          aluFlags;

   controlDecoder uDecoder (
      .instr(instr), .regW(regW), .memW(memW), .branch(branch),
      .memToReg(memToReg), .aluSrc(aluSrc), .noWrite(noWrite),
      .immSrc(immSrc), .regSrc(regSrc), .aluOp(aluOp), .flagW(flagW)
   );

   condUnit uCond (
      .clk(clk), .reset(reset), .instr(instr), .aluFlags(aluFlags),
      .flagW(flagW), .regW(regW), .memW(memW), .branch(branch),
      .noWrite(noWrite), .regWrite(regWrite), .memWrite(memWrite),
      .pcSrc(pcSrc)
   );

   datapath #(.RESET_PC(RESET_PC)) uDatapath (
      .clk(clk), .reset(reset), .instr(instr), .readData(readData),
      .regSrc(regSrc), .immSrc(immSrc), .aluOp(aluOp),
      .regWrite(regWrite), .aluSrc(aluSrc), .memToReg(memToReg),
      .pcSrc(pcSrc), .aluFlags(aluFlags), .pc(pc), .dataAdr(dataAdr),
      .writeData(writeData)
   );

endmodule

/* tbArmModel.svh */
// ---------------------------------------------------------------------------
// Instruction-level reference model of the ARMv4 subset core and random
// instruction generator, included by the testbench top
// ---------------------------------------------------------------------------
`ifndef TB_ARM_MODEL_SVH
`define TB_ARM_MODEL_SVH

// Architectural state
logic [31:0] mRegs [15];
logic [31:0] mPc;
logic [3:0]  mFlags;
logic [31:0] imem [logic [31:0]];
logic [31:0] dmem [logic [31:0]];

// Expected outputs and pending updates of the current instruction
logic [31:0] expAdr, expWd, expRead, nextPc, regData;
logic        expMemWr, wdCheck, regWe, memWe, nzWe, cvWe;
logic [3:0]  regIdx, newFlags;

task automatic initModel();
   for (int i = 0; i < 15; i++) mRegs[i] = '0;
   mFlags = '0;
   mPc    = RESET_PC;
endtask

function automatic logic [31:0] regVal(input logic [3:0] r);
   return (r == PC_REG) ? mPc + 32'd8 : mRegs[r];   // R15 reads two words ahead
endfunction

function automatic logic [31:0] memKey(input logic [31:0] a);
   return a & 32'h0000_03fc;   // 256 words, upper bits alias
endfunction

function automatic logic [31:0] memRead(input logic [31:0] a);
   logic [31:0] k;
   k = memKey(a);
   if (dmem.exists(k)) return dmem[k];
   return (k * 32'h9e37_79b1) ^ 32'h5a5a_0000;   // Unwritten word
endfunction

function automatic logic [31:0] shiftOp(input logic [31:0] x, input logic [1:0] sh,
                                        input logic [4:0] n);
   if (n == 5'd0) return x;
   case (sh)
      SH_LSL:  return x << n;
      SH_LSR:  return x >> n;
      SH_ASR:  return $signed(x) >>> n;
      default: return (x >> n) | (x << (6'd32 - n));
   endcase
endfunction

function automatic logic condHolds(input logic [3:0] cond);
   logic n, z, c, v;
   n = mFlags[FLAG_N];
   z = mFlags[FLAG_Z];
   c = mFlags[FLAG_C];
   v = mFlags[FLAG_V];
   case (cond)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return c;
      4'h3: return !c;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return c && !z;
      4'h9: return !c || z;
      4'ha: return n == v;
      4'hb: return n != v;
      4'hc: return !z && (n == v);
      4'hd: return z || (n != v);
      default: return 1'b1;
   endcase
endfunction

function automatic logic [31:0] randomInstr();
   logic [31:0] r;
   int unsigned kind;
   int          off;
   r        = $urandom;
   kind     = $urandom % 20;
   r[31:28] = ($urandom % 2 == 0) ? COND_AL : 4'($urandom % 15);
   if (kind < 12) begin
      r[27:26] = OP_DP;
      case ($urandom % 6)
         0: r[24:21] = CMD_ADD;
         1: r[24:21] = CMD_SUB;
         2: r[24:21] = CMD_AND;
         3: r[24:21] = CMD_ORR;
         4: r[24:21] = CMD_EOR;
         default: r[24:21] = CMD_CMP;
      endcase
      if (r[24:21] == CMD_CMP) r[20] = 1'b1;
      if (!r[25]) r[4] = 1'b0;   // Shift by constant only
      r[15:12] = 4'($urandom % 15);
   end else if (kind < 17) begin
      r[27:20] = {OP_MEM, 5'b01100, r[20]};   // Bit 20 picks LDR
      if (r[20]) r[15:12] = 4'($urandom % 15);
   end else begin
      off      = int'($urandom % 16) - 1;   // Forward only
      r[27:24] = {OP_BR, 2'b10};
      r[23:0]  = 24'(off);
   end
   return r;
endfunction

// Works out everything one instruction does, applied later by commitInstr
task automatic evalInstr(input logic [31:0] iw);
   logic [31:0] a, b;
   logic [32:0] sum;
   logic        pass, isSub, isArith;
   pass     = condHolds(iw[31:28]);
   a        = regVal(iw[19:16]);
   expMemWr = 1'b0;
   wdCheck  = 1'b0;
   expWd    = '0;
   regWe    = 1'b0;
   memWe    = 1'b0;
   nzWe     = 1'b0;
   cvWe     = 1'b0;
   newFlags = mFlags;
   nextPc   = mPc + 32'd4;
   regIdx   = iw[15:12];
   case (iw[27:26])
      OP_DP: begin
         b = iw[25] ? {24'b0, iw[7:0]} : shiftOp(regVal(iw[3:0]), iw[6:5], iw[11:7]);
         isSub   = (iw[24:21] == CMD_SUB) || (iw[24:21] == CMD_CMP);
         isArith = isSub || (iw[24:21] == CMD_ADD);
         case (iw[24:21])
            CMD_AND: sum = {1'b0, a & b};
            CMD_ORR: sum = {1'b0, a | b};
            CMD_EOR: sum = {1'b0, a ^ b};
            CMD_ADD: sum = {1'b0, a} + {1'b0, b};
            default: sum = {1'b0, a} - {1'b0, b};   // SUB and CMP
         endcase
         expAdr           = sum[31:0];
         newFlags[FLAG_N] = sum[31];
         newFlags[FLAG_Z] = (sum[31:0] == 32'b0);
         if (isSub) begin
            newFlags[FLAG_C] = (a >= b);   // Set when no borrow
            newFlags[FLAG_V] = (a[31] != b[31]) && (sum[31] != a[31]);
         end else begin
            newFlags[FLAG_C] = sum[32];
            newFlags[FLAG_V] = (a[31] == b[31]) && (sum[31] != a[31]);
         end
         nzWe  = pass && iw[20];
         cvWe  = nzWe && isArith;
         regWe = pass && (iw[24:21] != CMD_CMP);
      end
      OP_MEM: begin
         expAdr = a + {20'b0, iw[11:0]};
         if (iw[20]) begin
            regWe = pass;
         end else begin
            expWd    = regVal(iw[15:12]);
            wdCheck  = 1'b1;
            expMemWr = pass;
            memWe    = pass;
         end
      end
      default: begin
         expAdr = mPc + 32'd8 + {{6{iw[23]}}, iw[23:0], 2'b00};
         if (pass) nextPc = expAdr;
      end
   endcase
   expRead = memRead(expAdr);
   regData = (iw[27:26] == OP_MEM) ? expRead : expAdr;
endtask

task automatic commitInstr();
   if (regWe) mRegs[regIdx] = regData;
   if (memWe) dmem[memKey(expAdr)] = expWd;
   if (nzWe) begin
      mFlags[FLAG_N] = newFlags[FLAG_N];
      mFlags[FLAG_Z] = newFlags[FLAG_Z];
   end
   if (cvWe) begin
      mFlags[FLAG_C] = newFlags[FLAG_C];
      mFlags[FLAG_V] = newFlags[FLAG_V];
   end
   mPc = nextPc;
endtask

`endif

/* tbArm.sv */
// ---------------------------------------------------------------------------
// Testbench top: clock, reset, instruction and data memory models,
// random stimulus checked against the reference model, timeout
// ---------------------------------------------------------------------------
module tbArm import armPkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] RESET_PC    = 32'h0000_0100;
   localparam int          NUM_INSTR   = 3000;
   localparam int          CYCLE_LIMIT = NUM_INSTR + 50;
   localparam int          SEED        = 32'h218b;

   logic        clk;
   logic        reset;
   instrT       instr;
   logic [31:0] readData;
   logic [31:0] pc, dataAdr, writeData;
   logic        memWrite;
   int          cycleCount = 0;

   `include "tbArmModel.svh"

   armCore #(.RESET_PC(RESET_PC)) u_dut (
      .clk(clk), .reset(reset), .instr(instr), .readData(readData),
      .pc(pc), .memWrite(memWrite), .dataAdr(dataAdr), .writeData(writeData)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Run guard, reset cycles included
   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("*** FAILED ***");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic reportMismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
      $display("CHECK FAILED at %0t: %s is %h, expected %h (instr %h at pc %h)",
               $time, what, got, want, instr, mPc);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first mismatch");
   endtask

   initial begin
      logic [31:0] iw;
      reset    = 1'b1;
      instr    = '0;
      readData = '0;
      void'($urandom(SEED));
      initModel();
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      for (int n = 0; n < NUM_INSTR; n++) begin
         if (!imem.exists(mPc)) imem[mPc] = randomInstr();   // Fetch fills on demand
         iw = imem[mPc];
         evalInstr(iw);
         instr    = iw;
         readData = expRead;
         @(negedge clk);   // Outputs settled mid-cycle
         assert (pc === mPc)
            else reportMismatch("pc", pc, mPc);
         assert (memWrite === expMemWr)
            else reportMismatch("memWrite", 32'(memWrite), 32'(expMemWr));
         assert (dataAdr === expAdr)
            else reportMismatch("dataAdr", dataAdr, expAdr);
         if (wdCheck) begin
            assert (writeData === expWd)
               else reportMismatch("writeData", writeData, expWd);
         end
         @(posedge clk);
         commitInstr();
         #1;
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* armCore.f */
+incdir+.
armPkg.sv
alu.sv
regFile.sv
controlDecoder.sv
condUnit.sv
datapath.sv
armCore.sv
tbArm.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tbArm
FILELIST  := armCore.f
HEADERS   := tbArmModel.svh

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
